//--- compile.f
rtl/conv_pkg.sv
rtl/delay_line.sv
rtl/layer_fsm.sv
rtl/scan_counters.sv
rtl/window_timer.sv
rtl/conv_datapath.sv
rtl/conv_layer.sv
test/conv_layer_tb.sv

//--- Makefile
TOP := conv_layer_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP) | awk '{ print } /STATUS: PASS/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only --timing -Wall --top-module conv_layer -f compile.f

clean:
	rm -rf obj_dir

//--- test/conv_layer_tb.sv
`timescale 1ns/1ps

module conv_layer_tb;

    localparam int clock_period  = 20;
    localparam int ifm_size      = conv_pkg::ifm_size;
    localparam int kernel_size   = conv_pkg::kernel_size;
    localparam int ifm_depth     = conv_pkg::ifm_depth;
    localparam int filters       = conv_pkg::number_of_filters;
    localparam int ofm_size      = conv_pkg::ofm_size;
    localparam int map_points    = ifm_size * ifm_size;
    localparam int out_points    = ofm_size * ofm_size;
    localparam int taps          = kernel_size * kernel_size;
    localparam int weight_count  = taps * ifm_depth * filters;
    localparam int total_writes  = filters * out_points;
    localparam int passes        = filters * ifm_depth;
    localparam int frame_cycles  = passes * (map_points + 1);
    localparam int watchdog_time = (3 * frame_cycles * 2 + 1000) * clock_period;

    logic clk = 1'b0;
    logic reset;
    logic start_from_previous;
    logic end_from_next;
    logic end_to_previous;
    logic start_to_next;
    logic ifm_enable_read;
    logic [$clog2(map_points)-1:0]   ifm_address;
    logic wm_enable_read;
    logic [$clog2(weight_count)-1:0] wm_address;
    logic ofm_write;
    logic [$clog2(total_writes)-1:0] ofm_address;
    conv_pkg::psum_t  ofm_data;
    conv_pkg::pixel_t ifm_data = '0;
    conv_pkg::pixel_t wm_data  = '0;

    conv_pkg::pixel_t ifm_mem [ifm_depth][map_points];
    conv_pkg::pixel_t wm_mem  [weight_count];
    int  expected [total_writes];
    bit  written  [total_writes];

    // memory model state
    bit ifm_pending = 1'b0;
    bit wm_pending  = 1'b0;
    int ifm_request = 0;
    int ifm_channel = 0;
    int wm_request  = 0;
    int read_total  = 0;

    // monitor counters
    int next_address  = 0;
    int next_weight   = 0;
    int pass_count    = 0;
    int frame_reads   = 0;
    int ofm_count     = 0;
    int handoff_count = 0;

    conv_layer i_conv_layer (
        .clk, .reset, .start_from_previous, .end_from_next, .ifm_data, .wm_data,
        .end_to_previous, .start_to_next, .ifm_enable_read, .ifm_address,
        .wm_enable_read, .wm_address, .ofm_write, .ofm_address, .ofm_data
    );

    always #(clock_period / 2) clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "first error, run stopped");
    endtask

    task automatic fill_memories(input bit negative_weights);
        for (int c = 0; c < ifm_depth; c++)
            for (int a = 0; a < map_points; a++)
                ifm_mem[c][a] = negative_weights ? conv_pkg::pixel_t'($urandom % 128)
                                                 : conv_pkg::pixel_t'($urandom);
        for (int w = 0; w < weight_count; w++)
            wm_mem[w] = negative_weights ? conv_pkg::pixel_t'(-1 - int'($urandom % 128))
                                         : conv_pkg::pixel_t'($urandom);
    endtask

    // weights are laid out pass by pass, filter fastest
    task automatic compute_expected();
        int sum;
        for (int f = 0; f < filters; f++)
            for (int oy = 0; oy < ofm_size; oy++)
                for (int ox = 0; ox < ofm_size; ox++)
                begin
                    sum = 0;
                    for (int c = 0; c < ifm_depth; c++)
                        for (int r = 0; r < kernel_size; r++)
                            for (int k = 0; k < kernel_size; k++)
                                sum += int'(ifm_mem[c][(oy + r) * ifm_size + ox + k])
                                     * int'(wm_mem[(c * filters + f) * taps + r * kernel_size + k]);
                    expected[f * out_points + oy * ofm_size + ox] = (sum < 0) ? 0 : sum;
                end
    endtask

    task automatic start_frame();
        start_from_previous = 1'b1;
        @(negedge clk);
        start_from_previous = 1'b0;
    endtask

    task automatic finish_frame();
        while (!end_to_previous)
            @(negedge clk);
        assert (pass_count == passes)
            else report_failure($sformatf("Mismatch pass count: got %h, expected %h",
                                          pass_count, passes));
        // last window, tree latency, then the handoff
        repeat (conv_pkg::datapath_latency + 4) @(negedge clk);
        assert (ofm_count == total_writes)
            else report_failure($sformatf("Mismatch write count: got %h, expected %h",
                                          ofm_count, total_writes));
    endtask

    //////////////////////////////
    // memory models
    //////////////////////////////

    always @(negedge clk)
    begin
        if (ifm_pending)
            ifm_data = ifm_mem[ifm_channel][ifm_request];
        if (wm_pending)
            wm_data = wm_mem[wm_request];
        ifm_pending = ifm_enable_read;
        wm_pending  = wm_enable_read;
        if (ifm_enable_read)
        begin
            ifm_request = ifm_address;
            ifm_channel = (read_total / (map_points * filters)) % ifm_depth;  // filters first
            read_total++;
        end
        if (wm_enable_read)
            wm_request = wm_address;
    end

    //////////////////////////////
    // monitor
    //////////////////////////////

    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (start_from_previous)
            begin
                assert (end_to_previous)
                    else report_failure("start_from_previous accepted while the layer was busy");
                pass_count  = 0;
                frame_reads = 0;
                ofm_count   = 0;
                for (int i = 0; i < total_writes; i++)
                    written[i] = 1'b0;
            end
            if (ifm_enable_read)
            begin
                assert (ifm_address == next_address)
                    else report_failure($sformatf("Mismatch ifm_address: got %h, expected %h",
                                                  ifm_address, next_address));
                if (ifm_address == map_points - 1)
                    pass_count++;
                next_address = (next_address + 1) % map_points;
                frame_reads++;
            end
            if (wm_enable_read)
            begin
                assert (wm_address == next_weight)
                    else report_failure($sformatf("Mismatch wm_address: got %h, expected %h",
                                                  wm_address, next_weight));
                next_weight = (next_weight + 1) % weight_count;  // wraps at frame end
            end
            if (ofm_write)
            begin
                assert (ofm_address < total_writes && !written[ofm_address])
                    else report_failure($sformatf("ofm_address %h written twice or out of range",
                                                  ofm_address));
                assert (ofm_data == conv_pkg::psum_t'(expected[ofm_address]))
                    else report_failure($sformatf("Mismatch ofm_data at %h: got %h, expected %h",
                                                  ofm_address, ofm_data, expected[ofm_address]));
                written[ofm_address] = 1'b1;
                ofm_count++;
            end
            if (start_to_next)
                handoff_count++;
        end
    end

    assert property (@(posedge clk) disable iff (reset) start_to_next |-> end_from_next)
        else report_failure("start_to_next pulsed while end_from_next was low");
    assert property (@(posedge clk) disable iff (reset) start_to_next |=> !start_to_next)
        else report_failure("start_to_next stayed high for more than one cycle");
    assert property (@(posedge clk) disable iff (reset) ofm_write |-> !ofm_data[$bits(ofm_data)-1])
        else report_failure("ofm_data written with a negative value");

    initial
    begin
        #(watchdog_time);
        report_failure("watchdog expired before all frames were processed");
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial
    begin
        int held_reads;
        void'($urandom(32'h6318_2b18));
        reset               = 1'b1;
        start_from_previous = 1'b0;
        end_from_next       = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        assert (end_to_previous && !ofm_write && !start_to_next
                && !ifm_enable_read && !wm_enable_read)
            else report_failure("outputs not at their idle values after reset");

        // free downstream, random data
        fill_memories(1'b0);
        compute_expected();
        start_frame();
        finish_frame();
        assert (handoff_count == 1)
            else report_failure("no single start_to_next pulse after the first frame");

        // downstream busy from here, every sum negative
        end_from_next = 1'b0;
        fill_memories(1'b1);
        compute_expected();
        start_frame();
        finish_frame();
        assert (handoff_count == 1)
            else report_failure("start_to_next pulsed while downstream was busy");

        // third frame has to stall until the handoff
        fill_memories(1'b0);
        compute_expected();
        start_frame();
        repeat (2 * conv_pkg::fifo_size) @(negedge clk);
        held_reads = frame_reads;
        repeat (2 * conv_pkg::fifo_size) @(negedge clk);
        assert (frame_reads == held_reads && held_reads > 0 && held_reads < conv_pkg::fifo_size)
            else report_failure("input reads did not stop at the hold point");
        assert (ofm_count == 0 && handoff_count == 1)
            else report_failure("held frame produced output or a handoff");
        end_from_next = 1'b1;
        repeat (2) @(negedge clk);
        assert (handoff_count == 2)
            else report_failure("releasing end_from_next did not give one start_to_next pulse");
        finish_frame();
        assert (handoff_count == 3)
            else report_failure("no start_to_next pulse after the resumed frame");

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- rtl/conv_layer.sv
`timescale 1ns/1ps

module conv_layer #(
    parameter int  ifm_size          = conv_pkg::ifm_size,
    parameter int  kernel_size       = conv_pkg::kernel_size,
    parameter int  ifm_depth         = conv_pkg::ifm_depth,
    parameter int  number_of_filters = conv_pkg::number_of_filters,
    localparam int ofm_size          = ifm_size - kernel_size + 1,
    localparam int ifm_bits          = $clog2(ifm_size * ifm_size),
    localparam int wm_bits = $clog2(kernel_size * kernel_size * ifm_depth * number_of_filters),
    localparam int ofm_bits          = $clog2(number_of_filters * ofm_size * ofm_size),
    localparam int filter_bits       = (number_of_filters > 1) ? $clog2(number_of_filters) : 1,
    localparam int depth_bits        = (ifm_depth > 1) ? $clog2(ifm_depth) : 1
)(
    input  logic                clk,
    input  logic                reset,
    input  logic                start_from_previous,
    input  logic                end_from_next,
    input  conv_pkg::pixel_t    ifm_data,
    input  conv_pkg::pixel_t    wm_data,
    output logic                end_to_previous,
    output logic                start_to_next,
    output logic                ifm_enable_read,
    output logic [ifm_bits-1:0] ifm_address,
    output logic                wm_enable_read,
    output logic [wm_bits-1:0]  wm_address,
    output logic                ofm_write,
    output logic [ofm_bits-1:0] ofm_address,
    output conv_pkg::psum_t     ofm_data
);

    logic                   scan_enable;
    logic                   pass_start;
    logic                   scan_tick;
    logic                   hold_point;
    logic                   filter_tick;
    logic                   depth_tick;
    logic                   frame_written;
    logic                   conv_enable;
    logic                   psum_write;
    logic [depth_bits-1:0]  depth_index;
    logic [filter_bits-1:0] filter_index;
    logic [filter_bits-1:0] psum_address;
    logic [1:0]             channel_flags;    // first, last
    logic [1:0]             channel_flags_d;

    assign ifm_enable_read = scan_enable;
    assign channel_flags   = {depth_index == '0, depth_index == depth_bits'(ifm_depth - 1)};

    layer_fsm i_layer_fsm (
        .clk, .reset, .start_from_previous, .end_from_next,
        .scan_tick, .hold_point, .filter_tick, .depth_tick, .frame_written,
        .scan_enable, .pass_start, .end_to_previous, .start_to_next
    );

    scan_counters #(
        .ifm_size(ifm_size), .kernel_size(kernel_size),
        .ifm_depth(ifm_depth), .number_of_filters(number_of_filters)
    ) i_scan_counters (
        .clk, .reset, .scan_enable, .pass_start,
        .ifm_address, .wm_address, .wm_enable_read,
        .scan_tick, .hold_point, .filter_tick, .depth_tick,
        .depth_index, .filter_index
    );

    window_timer #(.ifm_size(ifm_size), .kernel_size(kernel_size)) i_window_timer (
        .clk, .reset, .shift_enable(scan_enable), .conv_enable
    );

    // control travels with the sum through the tree
    delay_line #(.payload_t(logic), .depth(conv_pkg::datapath_latency)) i_enable_delay (
        .clk, .reset, .data_in(conv_enable), .data_out(psum_write)
    );

    delay_line #(
        .payload_t(logic [filter_bits-1:0]), .depth(conv_pkg::datapath_latency)
    ) i_address_delay (
        .clk, .reset, .data_in(filter_index), .data_out(psum_address)
    );

    delay_line #(.payload_t(logic [1:0]), .depth(conv_pkg::datapath_latency)) i_channel_delay (
        .clk, .reset, .data_in(channel_flags), .data_out(channel_flags_d)
    );

    conv_datapath #(
        .ifm_size(ifm_size), .kernel_size(kernel_size), .number_of_filters(number_of_filters)
    ) i_conv_datapath (
        .clk, .reset, .shift_enable(scan_enable), .ifm_data,
        .weight_load(wm_enable_read), .wm_data, .conv_enable,
        .psum_write, .psum_address,
        .first_channel(channel_flags_d[1]), .last_channel(channel_flags_d[0]),
        .ofm_write, .ofm_address, .ofm_data, .frame_written
    );

endmodule

//--- rtl/conv_datapath.sv
`timescale 1ns/1ps

module conv_datapath #(
    parameter int  ifm_size          = conv_pkg::ifm_size,
    parameter int  kernel_size       = conv_pkg::kernel_size,
    parameter int  number_of_filters = conv_pkg::number_of_filters,
    localparam int ofm_size          = ifm_size - kernel_size + 1,
    localparam int map_points        = ofm_size * ofm_size,
    localparam int address_bits      = $clog2(number_of_filters * map_points),
    localparam int filter_bits       = (number_of_filters > 1) ? $clog2(number_of_filters) : 1
)(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    shift_enable,
    input  conv_pkg::pixel_t        ifm_data,
    input  logic                    weight_load,
    input  conv_pkg::pixel_t        wm_data,
    input  logic                    conv_enable,
    input  logic                    psum_write,
    input  logic [filter_bits-1:0]  psum_address,
    input  logic                    first_channel,
    input  logic                    last_channel,
    output logic                    ofm_write,
    output logic [address_bits-1:0] ofm_address,
    output conv_pkg::psum_t         ofm_data,
    output logic                    frame_written
);

    localparam int fifo_size = (kernel_size - 1) * ifm_size + kernel_size;
    localparam int taps      = kernel_size * kernel_size;

    logic                          shift_valid;
    logic                          load_valid;
    logic [$clog2(map_points)-1:0] write_count;

    conv_pkg::pixel_t line_buffer [fifo_size];
    conv_pkg::pixel_t kernel      [taps];
    conv_pkg::pixel_t window_reg  [taps];
    conv_pkg::pixel_t weight_reg  [taps];
    conv_pkg::psum_t  product     [taps];
    conv_pkg::psum_t  row_sum     [kernel_size];
    conv_pkg::psum_t  window_sum;
    conv_pkg::psum_t  stored;
    conv_pkg::psum_t  new_sum;
    conv_pkg::psum_t  psum_buffer [number_of_filters * map_points];

    // memories answer one cycle after the read
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shift_valid <= 1'b0;
            load_valid  <= 1'b0;
        end
        else
        begin
            shift_valid <= shift_enable;
            load_valid  <= weight_load;
        end
    end

    always_ff @(posedge clk)
    begin
        if (shift_valid)
        begin
            line_buffer[0] <= ifm_data;  // newest pixel
            for (int i = 1; i < fifo_size; i++)
                line_buffer[i] <= line_buffer[i-1];
        end
        if (load_valid)
        begin
            kernel[taps-1] <= wm_data;
            for (int i = 0; i < taps - 1; i++)
                kernel[i] <= kernel[i+1];
        end
    end

    //////////////////////////////
    // multiply and adder tree
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        conv_pkg::psum_t acc;
        if (conv_enable)
        begin
            for (int r = 0; r < kernel_size; r++)
                for (int c = 0; c < kernel_size; c++)
                begin
                    window_reg[r*kernel_size+c] <=
                        line_buffer[(kernel_size-1-r)*ifm_size + (kernel_size-1-c)];
                    weight_reg[r*kernel_size+c] <= kernel[r*kernel_size+c];
                end
        end
        for (int i = 0; i < taps; i++)
            product[i] <= window_reg[i] * weight_reg[i];
        for (int r = 0; r < kernel_size; r++)
        begin
            acc = '0;
            for (int c = 0; c < kernel_size; c++)
                acc = acc + product[r*kernel_size+c];
            row_sum[r] <= acc;
        end
        acc = '0;
        for (int r = 0; r < kernel_size; r++)
            acc = acc + row_sum[r];
        window_sum <= acc;
    end

    //////////////////////////////
    // partial sums and relu
    //////////////////////////////

    assign ofm_address = address_bits'(psum_address) * address_bits'(map_points)
                       + address_bits'(write_count);
    assign stored      = first_channel ? '0 : psum_buffer[ofm_address];
    assign new_sum     = window_sum + stored;
    assign ofm_write   = psum_write && last_channel;
    assign ofm_data    = (new_sum < 0) ? '0 : new_sum;

    always_ff @(posedge clk)
    begin
        if (psum_write && !last_channel)
            psum_buffer[ofm_address] <= new_sum;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            write_count   <= '0;
            frame_written <= 1'b0;
        end
        else
        begin
            frame_written <= ofm_write && write_count == map_points - 1
                             && psum_address == number_of_filters - 1;
            if (psum_write)
                write_count <= (write_count == map_points - 1) ? '0 : write_count + 1'b1;
        end
    end

endmodule

//--- rtl/window_timer.sv
`timescale 1ns/1ps

module window_timer #(
    parameter int ifm_size    = conv_pkg::ifm_size,
    parameter int kernel_size = conv_pkg::kernel_size
)(
    input  logic clk,
    input  logic reset,
    input  logic shift_enable,
    output logic conv_enable
);

    localparam int fifo_size = (kernel_size - 1) * ifm_size + kernel_size;
    localparam int ofm_size  = ifm_size - kernel_size + 1;

    typedef enum logic [1:0] {st_fill, st_ready, st_not_ready} timer_state_t;

    timer_state_t                   state;
    logic                           shift_valid;  // read enable at data time
    logic [$clog2(fifo_size)-1:0]   fill_count;
    logic [$clog2(ofm_size+1)-1:0]  phase_count;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            shift_valid <= 1'b0;
            state       <= st_fill;
            fill_count  <= '0;
            phase_count <= '0;
        end
        else
        begin
            shift_valid <= shift_enable;
            case (state)
                st_fill:
                begin
                    // pauses while the scan is held
                    if (shift_valid && fill_count == fifo_size - 1)
                    begin
                        fill_count  <= '0;
                        phase_count <= '0;
                        state       <= st_ready;
                    end
                    else if (shift_valid)
                        fill_count <= fill_count + 1'b1;
                end
                st_ready:
                begin
                    phase_count <= phase_count + 1'b1;
                    if (!shift_valid)
                        state <= st_fill;
                    else if (phase_count == ofm_size - 1)
                    begin
                        phase_count <= '0;
                        state       <= st_not_ready;
                    end
                end
                default:
                begin
                    phase_count <= phase_count + 1'b1;
                    if (!shift_valid)
                        state <= st_fill;
                    else if (phase_count == kernel_size - 2)  // window straddles a row edge
                    begin
                        phase_count <= '0;
                        state       <= st_ready;
                    end
                end
            endcase
        end
    end

    assign conv_enable = (state == st_ready);

endmodule

//--- rtl/scan_counters.sv
`timescale 1ns/1ps

module scan_counters #(
    parameter int  ifm_size          = conv_pkg::ifm_size,
    parameter int  kernel_size       = conv_pkg::kernel_size,
    parameter int  ifm_depth         = conv_pkg::ifm_depth,
    parameter int  number_of_filters = conv_pkg::number_of_filters,
    localparam int map_points        = ifm_size * ifm_size,
    localparam int taps              = kernel_size * kernel_size,
    localparam int weights           = taps * ifm_depth * number_of_filters,
    localparam int filter_bits       = (number_of_filters > 1) ? $clog2(number_of_filters) : 1,
    localparam int depth_bits        = (ifm_depth > 1) ? $clog2(ifm_depth) : 1
)(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          scan_enable,
    input  logic                          pass_start,
    output logic [$clog2(map_points)-1:0] ifm_address,
    output logic [$clog2(weights)-1:0]    wm_address,
    output logic                          wm_enable_read,
    output logic                          scan_tick,
    output logic                          hold_point,
    output logic                          filter_tick,
    output logic                          depth_tick,
    output logic [depth_bits-1:0]         depth_index,
    output logic [filter_bits-1:0]        filter_index
);

    localparam int fifo_size = (kernel_size - 1) * ifm_size + kernel_size;

    logic [filter_bits-1:0]  filter_count;
    logic [filter_bits-1:0]  filter_d1;
    logic [depth_bits-1:0]   depth_count;
    logic [depth_bits-1:0]   depth_d1;
    logic [$clog2(taps)-1:0] load_count;

    assign scan_tick   = scan_enable && ifm_address == map_points - 1;
    assign hold_point  = scan_enable && ifm_address == fifo_size - 3;  // before window fills
    assign filter_tick = scan_tick && filter_count == number_of_filters - 1;
    assign depth_tick  = scan_tick && depth_count == ifm_depth - 1;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            ifm_address <= '0;
        else if (scan_tick)
            ifm_address <= '0;
        else if (scan_enable)
            ifm_address <= ifm_address + 1'b1;
    end

    // filters first, then channels
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            filter_count <= '0;
            depth_count  <= '0;
        end
        else if (filter_tick)
        begin
            filter_count <= '0;
            depth_count  <= depth_tick ? '0 : depth_count + 1'b1;
        end
        else if (scan_tick)
            filter_count <= filter_count + 1'b1;
    end

    // indices follow the window, two cycles behind the read
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            filter_d1    <= '0;
            filter_index <= '0;
            depth_d1     <= '0;
            depth_index  <= '0;
        end
        else
        begin
            filter_d1    <= filter_count;
            filter_index <= filter_d1;
            depth_d1     <= depth_count;
            depth_index  <= depth_d1;
        end
    end

    //////////////////////////////
    // weight fetch
    //////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wm_enable_read <= 1'b0;
            load_count     <= '0;
            wm_address     <= '0;
        end
        else
        begin
            if (pass_start)
            begin
                wm_enable_read <= 1'b1;
                load_count     <= '0;
            end
            else if (wm_enable_read)
            begin
                load_count <= load_count + 1'b1;
                if (load_count == taps - 1)
                    wm_enable_read <= 1'b0;
            end
            if (wm_enable_read)
                wm_address <= (wm_address == weights - 1) ? '0 : wm_address + 1'b1;
        end
    end

endmodule

//--- rtl/layer_fsm.sv
`timescale 1ns/1ps

module layer_fsm
(
    input  logic clk,
    input  logic reset,
    input  logic start_from_previous,
    input  logic end_from_next,
    input  logic scan_tick,
    input  logic hold_point,
    input  logic filter_tick,
    input  logic depth_tick,
    input  logic frame_written,
    output logic scan_enable,
    output logic pass_start,
    output logic end_to_previous,
    output logic start_to_next
);

    typedef enum logic [1:0] {st_idle, st_read, st_finish, st_hold} pass_state_t;
    typedef enum logic {ho_free, ho_full} handoff_state_t;

    pass_state_t    state, state_next;
    handoff_state_t handoff;

    //////////////////////////////
    // pass machine
    //////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= st_idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next      = state;
        scan_enable     = 1'b0;
        pass_start      = 1'b0;
        end_to_previous = 1'b0;
        case (state)
            st_idle:
            begin
                end_to_previous = 1'b1;
                if (start_from_previous)
                begin
                    pass_start = 1'b1;
                    state_next = st_read;
                end
            end
            st_read:
            begin
                scan_enable = 1'b1;
                // old output still owned downstream
                if (hold_point && handoff == ho_full && !end_from_next)
                    state_next = st_hold;
                else if (filter_tick && depth_tick)
                    state_next = st_idle;  // last filter, last channel
                else if (scan_tick)
                    state_next = st_finish;
            end
            st_finish:
            begin
                pass_start = 1'b1;
                state_next = st_read;
            end
            st_hold:
            begin
                if (end_from_next)
                    state_next = st_read;
            end
            default:
                state_next = st_idle;
        endcase
    end

    //////////////////////////////
    // output handoff
    //////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            handoff <= ho_free;
        else if (handoff == ho_free && frame_written)
            handoff <= ho_full;
        else if (handoff == ho_full && end_from_next)
            handoff <= ho_free;
    end

    assign start_to_next = (handoff == ho_full) && end_from_next;

endmodule

//--- rtl/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  depth     = 1
)(
    input  logic     clk,
    input  logic     reset,
    input  payload_t data_in,
    output payload_t data_out
);

    payload_t stage [depth];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < depth; i++)
                stage[i] <= '0;
        end
        else
        begin
            stage[0] <= data_in;
            for (int i = 1; i < depth; i++)
                stage[i] <= stage[i-1];
        end
    end

    assign data_out = stage[depth-1];

endmodule

//--- rtl/conv_pkg.sv
package conv_pkg;

    // layer geometry
    localparam int ifm_size          = 8;
    localparam int kernel_size       = 3;
    localparam int ifm_depth         = 2;
    localparam int number_of_filters = 2;
    localparam int ofm_size          = ifm_size - kernel_size + 1;

    // data widths
    localparam int data_width = 8;
    localparam int acc_width  = 20;

    // k-1 full rows plus k pixels
    localparam int fifo_size = (kernel_size - 1) * ifm_size + kernel_size;

    localparam int datapath_latency = 4;  // conv_enable to psum write

    typedef logic signed [data_width-1:0] pixel_t;
    typedef logic signed [acc_width-1:0]  psum_t;

endpackage
